//--- axis_hub_switch.sv
`timescale 1ns/100ps
`default_nettype none

`include "switch_defs.svh"

module axis_hub_switch import axis_pkg::*, switch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,

    // hub port
    input  wire axis_fwd_t   hub_in,
    output wire              hub_in_ready,
    output wire axis_fwd_t   hub_out,
    input  wire              hub_out_ready,

    // spoke ports 1..7
    input  wire spoke_fwd_t  spoke_in,
    output wire spoke_mask_t spoke_in_ready,
    output wire spoke_fwd_t  spoke_out,
    input  wire spoke_mask_t spoke_out_ready
);

    wire spoke_fwd_t  demux_fwd;    // demux to spoke slices
    wire spoke_mask_t slice_ready;
    wire axis_fwd_t   arb_fwd;      // arbiter to hub slice
    wire              arb_ready;

    hub_dest_demux i_hub_dest_demux (
        .hub_in      (hub_in),
        .hub_ready   (hub_in_ready),
        .spoke_out   (demux_fwd),
        .spoke_ready (slice_ready)
    );

    for (genvar i = 0; i < `NUM_SPOKES; i++) begin : g_spoke_slice
        axis_skid_slice i_spoke_slice (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_fwd    (demux_fwd[i]),
            .in_ready  (slice_ready[i]),
            .out_fwd   (spoke_out[i]),
            .out_ready (spoke_out_ready[i])
        );
    end

    spoke_priority_arbiter i_spoke_priority_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .spoke_in    (spoke_in),
        .spoke_ready (spoke_in_ready),
        .hub_out     (arb_fwd),
        .hub_ready   (arb_ready)
    );

    // registers the merged spoke traffic
    axis_skid_slice i_hub_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_fwd    (arb_fwd),
        .in_ready  (arb_ready),
        .out_fwd   (hub_out),
        .out_ready (hub_out_ready)
    );

endmodule

`default_nettype wire

//--- axis_pkg.sv
`default_nettype none

`include "switch_defs.svh"

package axis_pkg;

    typedef logic [`AXIS_DATA_W-1:0] axis_data_t;
    typedef logic [`AXIS_DEST_W-1:0] axis_dest_t;
    typedef logic [`AXIS_ID_W-1:0]   axis_id_t;

    // one stream beat without handshake bits
    typedef struct packed {
        axis_data_t tdata;
        axis_dest_t tdest;
        axis_id_t   tid;
    } axis_beat_t;

    // forward half of a link
    // ready runs back on its own wire
    typedef struct packed {
        logic       valid;
        axis_beat_t beat;
    } axis_fwd_t;

endpackage

`default_nettype wire

//--- axis_skid_slice.sv
`timescale 1ns/100ps
`default_nettype none

module axis_skid_slice import axis_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire axis_fwd_t in_fwd,
    output logic           in_ready,
    output axis_fwd_t      out_fwd,
    input  wire            out_ready
);

    logic       main_vld_q;    // output register
    axis_beat_t main_beat_q;
    logic       skid_vld_q;    // catches the beat taken while output stalls
    axis_beat_t skid_beat_q;
    logic       push;
    logic       main_free;
    logic [1:0] occupancy;

    assign in_ready  = !skid_vld_q;   // straight from a flop
    assign push      = in_fwd.valid && in_ready;
    assign main_free = !main_vld_q || out_ready;
    assign occupancy = {1'b0, main_vld_q} + {1'b0, skid_vld_q};

    assign out_fwd = '{valid: main_vld_q, beat: main_beat_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_vld_q <= 1'b0;
            skid_vld_q <= 1'b0;
        end else if (main_free) begin
            // skid drains first, input is held off meanwhile
            main_vld_q <= skid_vld_q || push;
            skid_vld_q <= 1'b0;
        end else if (push) begin
            skid_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free && skid_vld_q) begin
            main_beat_q <= skid_beat_q;
        end else if (main_free && push) begin
            main_beat_q <= in_fwd.beat;
        end
        if (!main_free && push) begin
            skid_beat_q <= in_fwd.beat;   // output busy
        end
    end

    // stalled beat must hold until taken
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        main_vld_q && !out_ready |=> main_vld_q && $stable(main_beat_q))
        else $error("slice output changed while stalled");

    // a full slice keeps both beats until the output moves
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy == 2'd2 && !out_ready |=> occupancy == 2'd2 && $stable(skid_beat_q))
        else $error("slice written while full");

endmodule

`default_nettype wire

//--- hub_dest_demux.sv
`timescale 1ns/100ps
`default_nettype none

`include "switch_defs.svh"

module hub_dest_demux import axis_pkg::*, switch_pkg::*; (
    input  wire axis_fwd_t   hub_in,
    output logic             hub_ready,
    output spoke_fwd_t       spoke_out,
    input  wire spoke_mask_t spoke_ready
);

    axis_dest_t  dest_m1;
    spoke_idx_t  sel;
    logic        dest_hit;
    spoke_mask_t hit_mask;
    spoke_mask_t valid_vec;

    // tdest 1..7 addresses a spoke
    assign dest_hit = (hub_in.beat.tdest != `AXIS_DEST_W'(`HUB_DEST)) &&
                      (hub_in.beat.tdest <= `AXIS_DEST_W'(`NUM_SPOKES));

    assign dest_m1 = hub_in.beat.tdest - `AXIS_DEST_W'(1);
    assign sel     = spoke_idx_t'(dest_m1);   // spoke n at index n-1

    assign hit_mask  = dest_hit ? (spoke_mask_t'(1) << sel) : '0;
    assign valid_vec = hit_mask & {`NUM_SPOKES{hub_in.valid}};

    // stray destinations are swallowed right away
    assign hub_ready = dest_hit ? |(hit_mask & spoke_ready) : 1'b1;

    always_comb begin
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            spoke_out[i].valid = valid_vec[i];
            spoke_out[i].beat  = hub_in.beat;   // payload fans out, valid picks
        end
    end

    // a steered beat lands only on the spoke its tdest names
    always_comb begin
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            if (valid_vec[i]) begin
                assert (hub_in.beat.tdest == `AXIS_DEST_W'(i + 1))
                    else $error("hub beat steered to the wrong spoke");
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the hub switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_axis_hub_switch

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

//--- spoke_priority_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "switch_defs.svh"

module spoke_priority_arbiter import axis_pkg::*, switch_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire spoke_fwd_t  spoke_in,
    output spoke_mask_t      spoke_ready,
    output axis_fwd_t        hub_out,
    input  wire              hub_ready
);

    spoke_mask_t  cand;     // valid and addressed to the hub
    spoke_mask_t  stray;    // valid but addressed elsewhere
    spoke_mask_t  grant;
    spoke_grant_t pick;     // lowest candidate this cycle
    spoke_grant_t lock_q;   // grant held across a stall
    spoke_grant_t cur;

    always_comb begin
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            cand[i]  = spoke_in[i].valid &&
                       (spoke_in[i].beat.tdest == `AXIS_DEST_W'(`HUB_DEST));
            stray[i] = spoke_in[i].valid &&
                       (spoke_in[i].beat.tdest != `AXIS_DEST_W'(`HUB_DEST));
        end
    end

    // scan high to low so the lowest index is written last
    always_comb begin
        pick = '0;
        for (int i = `NUM_SPOKES - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick.valid = 1'b1;
                pick.idx   = spoke_idx_t'(i);
            end
        end
    end

    assign cur   = lock_q.valid ? lock_q : pick;
    assign grant = cur.valid ? (spoke_mask_t'(1) << cur.idx) : '0;

    assign hub_out = '{valid: cur.valid, beat: spoke_in[cur.idx].beat};

    // strays are dropped, losers wait
    assign spoke_ready = stray | (grant & {`NUM_SPOKES{hub_ready}});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_q <= '0;
        end else if (cur.valid && !hub_ready) begin
            lock_q <= cur;       // keep it until the hub side takes it
        end else begin
            lock_q <= '0;        // transfer or idle
        end
    end

    // with no grant held the lowest waiting spoke goes first
    a_grant_lowest: assert property (@(posedge clk) disable iff (!rst_n)
        !lock_q.valid |-> (cand & (grant - spoke_mask_t'(1))) == '0)
        else $error("lower spoke passed over by the grant");

    // upstream must keep the locked beat up
    a_lock_valid: assert property (@(posedge clk) disable iff (!rst_n)
        lock_q.valid |-> cand[lock_q.idx])
        else $error("locked spoke dropped its hub beat");

endmodule

`default_nettype wire

//--- switch_defs.svh
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

// link format shared by every block of the switch
`define AXIS_DATA_W 128
`define AXIS_DEST_W 4
`define AXIS_ID_W   2

// port 0 is the hub, ports 1 to 7 are the spokes
`define NUM_SPOKES  7

// tdest value that addresses the hub
`define HUB_DEST    0

`endif

//--- switch_pkg.sv
`default_nettype none

`include "switch_defs.svh"

package switch_pkg;

    import axis_pkg::*;

    // spoke n lives at index n-1
    typedef logic [$clog2(`NUM_SPOKES)-1:0] spoke_idx_t;

    typedef logic [`NUM_SPOKES-1:0] spoke_mask_t;   // one bit per spoke

    // arbiter grant as index plus valid
    typedef struct packed {
        logic       valid;
        spoke_idx_t idx;
    } spoke_grant_t;

    typedef axis_fwd_t [`NUM_SPOKES-1:0] spoke_fwd_t;   // all spoke links side by side

endpackage

`default_nettype wire

//--- tb_axis_hub_switch.sv
`timescale 1ns/100ps
`default_nettype none

`include "switch_defs.svh"

module tb_axis_hub_switch import axis_pkg::*, switch_pkg::*; ();

    localparam int NUM_HUB_BEATS   = 200;
    localparam int NUM_SPOKE_BEATS = 40;    // per spoke
    localparam int TOTAL_BEATS     = NUM_HUB_BEATS + `NUM_SPOKES * NUM_SPOKE_BEATS;
    localparam int CYCLE_LIMIT     = 4 * TOTAL_BEATS + 200;

    logic        clk;
    logic        rst_n;
    axis_fwd_t   hub_in;
    logic        hub_in_ready;
    axis_fwd_t   hub_out;
    logic        hub_out_ready;
    spoke_fwd_t  spoke_in;
    spoke_mask_t spoke_in_ready;
    spoke_fwd_t  spoke_out;
    spoke_mask_t spoke_out_ready;

    // expected beats per output, oldest first
    axis_beat_t  hub_q[$];
    axis_beat_t  spoke_q[`NUM_SPOKES][$];

    // beat due at the coming rising edge
    axis_beat_t  hub_exp;
    logic        hub_exp_ok;
    axis_beat_t  spoke_exp[`NUM_SPOKES];
    spoke_mask_t spoke_exp_ok;

    spoke_mask_t cand;          // spokes holding a hub beat
    spoke_mask_t exp_grant;
    spoke_mask_t lock_mask;     // reference grant held over a stall
    spoke_mask_t lock_next;

    logic        hub_acc;       // held beat taken at the coming edge
    spoke_mask_t spoke_acc;
    int          hub_sent;
    int          spoke_sent[`NUM_SPOKES];
    logic        in_seen;
    logic        hub_stray;
    spoke_mask_t out_valids;

    int unsigned lcg_state = 3;
    int          cycle_cnt;
    int          mismatch_cnt;
    int          fault_cnt;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axis_hub_switch i_axis_hub_switch (
        .clk             (clk),
        .rst_n           (rst_n),
        .hub_in          (hub_in),
        .hub_in_ready    (hub_in_ready),
        .hub_out         (hub_out),
        .hub_out_ready   (hub_out_ready),
        .spoke_in        (spoke_in),
        .spoke_in_ready  (spoke_in_ready),
        .spoke_out       (spoke_out),
        .spoke_out_ready (spoke_out_ready)
    );

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (next_rand() >> 16) % n;   // low bits of an lcg are weak
    endfunction

    function automatic axis_beat_t make_beat(input axis_dest_t dest);
        axis_beat_t beat;
        for (int w = 0; w < `AXIS_DATA_W / 32; w++) begin
            beat.tdata[32*w +: 32] = next_rand();
        end
        beat.tdest = dest;
        beat.tid   = axis_id_t'(next_rand() >> 30);
        return beat;
    endfunction

    function automatic spoke_mask_t lowest_set(input spoke_mask_t m);
        return m & (~m + spoke_mask_t'(1));
    endfunction

    function automatic logic traffic_done();
        logic busy;
        busy = (hub_sent < NUM_HUB_BEATS) || hub_in.valid || hub_out.valid ||
               (hub_q.size() != 0);
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            busy = busy || (spoke_sent[i] < NUM_SPOKE_BEATS) || spoke_in[i].valid ||
                   spoke_out[i].valid || (spoke_q[i].size() != 0);
        end
        return !busy;
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            cand[i] = spoke_in[i].valid &&
                      (spoke_in[i].beat.tdest == axis_dest_t'(`HUB_DEST));
            out_valids[i] = spoke_out[i].valid;
        end
    end

    // lowest index wins unless a grant is held
    assign exp_grant = (lock_mask != '0) ? lock_mask : lowest_set(cand);

    assign hub_stray = hub_in.valid &&
                       ((hub_in.beat.tdest == axis_dest_t'(`HUB_DEST)) ||
                        (hub_in.beat.tdest > axis_dest_t'(`NUM_SPOKES)));

    task automatic init_inputs();
        hub_in          = '0;
        spoke_in        = '0;
        hub_out_ready   = 1'b0;
        spoke_out_ready = '0;
        hub_exp         = '0;
        hub_exp_ok      = 1'b1;
        spoke_exp_ok    = '1;
        lock_mask       = '0;
        lock_next       = '0;
        hub_acc         = 1'b0;
        spoke_acc       = '0;
        hub_sent        = 0;
        in_seen         = 1'b0;
        mismatch_cnt    = 0;
        fault_cnt       = 0;
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            spoke_exp[i]  = '0;
            spoke_sent[i] = 0;
        end
    endtask

    // sources hold each beat until it is taken
    task automatic drive_inputs();
        axis_dest_t dest;
        if (hub_acc || !hub_in.valid) begin
            hub_in.valid = 1'b0;
            if (hub_sent < NUM_HUB_BEATS && rand_below(4) != 0) begin
                hub_in.valid = 1'b1;
                hub_in.beat  = make_beat(axis_dest_t'(rand_below(16)));
                hub_sent++;
            end
        end
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            if (spoke_acc[i] || !spoke_in[i].valid) begin
                spoke_in[i].valid = 1'b0;
                if (spoke_sent[i] < NUM_SPOKE_BEATS && rand_below(4) != 0) begin
                    if (rand_below(4) != 0) begin
                        dest = axis_dest_t'(`HUB_DEST);
                    end else begin
                        dest = axis_dest_t'(1 + rand_below(15));   // stray beat
                    end
                    spoke_in[i].valid = 1'b1;
                    spoke_in[i].beat  = make_beat(dest);
                    spoke_sent[i]++;
                end
            end
            spoke_out_ready[i] = (rand_below(4) != 0);
        end
        hub_out_ready = (rand_below(4) != 0);
    endtask

    // everything here is stable until the coming rising edge
    task automatic record_handshakes();
        int dest;
        hub_exp_ok = 1'b1;
        if (hub_out.valid && hub_out_ready) begin
            if (hub_q.size() > 0) begin
                hub_exp = hub_q.pop_front();
            end else begin
                hub_exp_ok = 1'b0;
            end
        end
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            spoke_exp_ok[i] = 1'b1;
            if (spoke_out[i].valid && spoke_out_ready[i]) begin
                if (spoke_q[i].size() > 0) begin
                    spoke_exp[i] = spoke_q[i].pop_front();
                end else begin
                    spoke_exp_ok[i] = 1'b0;
                end
            end
        end
        hub_acc = hub_in.valid && hub_in_ready;
        if (hub_acc) begin
            dest = int'(hub_in.beat.tdest);
            if (dest != `HUB_DEST && dest <= `NUM_SPOKES) begin
                spoke_q[dest - 1].push_back(hub_in.beat);   // spoke n at index n-1
            end
        end
        for (int i = 0; i < `NUM_SPOKES; i++) begin
            spoke_acc[i] = spoke_in[i].valid && spoke_in_ready[i];
            if (spoke_acc[i] && cand[i]) begin
                hub_q.push_back(spoke_in[i].beat);
            end
        end
        if (hub_acc || spoke_acc != '0) begin
            in_seen = 1'b1;
        end
        // a granted beat left waiting keeps the grant
        lock_next = ((cand & spoke_in_ready) == '0) ? exp_grant : '0;
    endtask

    initial begin
        init_inputs();
        wait (rst_n === 1'b1);
        while (!traffic_done()) begin
            @(negedge clk);
            lock_mask = lock_next;
            drive_inputs();
            #1;
            record_handshakes();
        end
        repeat (2) @(negedge clk);
        $display("mismatches: %0d, other failures: %0d", mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles with traffic still pending", cycle_cnt);
        $display("mismatches: %0d, other failures: %0d", mismatch_cnt, fault_cnt);
        $display("TEST FAIL");
        $finish;
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !in_seen |-> !hub_out.valid && out_valids == '0)
        else begin
            $display("an output went valid before any input beat");
            fault_cnt++;
        end

    a_hub_discard: assert property (@(posedge clk) disable iff (!rst_n)
        hub_stray |-> hub_in_ready)
        else begin
            $display("hub beat with tdest %0d was not accepted", hub_in.beat.tdest);
            fault_cnt++;
        end

    a_hub_extra: assert property (@(posedge clk) disable iff (!rst_n)
        hub_out.valid && hub_out_ready |-> hub_exp_ok)
        else begin
            $display("hub_out delivered a beat that no spoke sent");
            fault_cnt++;
        end

    a_hub_value: assert property (@(posedge clk) disable iff (!rst_n)
        hub_out.valid && hub_out_ready && hub_exp_ok |-> hub_out.beat == hub_exp)
        else begin
            $display("MISMATCH hub_out.beat expected %h actual %h",
                     hub_exp, $sampled(hub_out.beat));
            mismatch_cnt++;
        end

    a_hub_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hub_out.valid && !hub_out_ready |=> hub_out.valid && $stable(hub_out.beat))
        else begin
            $display("hub_out changed while stalled");
            fault_cnt++;
        end

    a_arb_order: assert property (@(posedge clk) disable iff (!rst_n)
        (spoke_in_ready & cand & ~exp_grant) == '0)
        else begin
            $display("MISMATCH spoke_in_ready expected %h actual %h",
                     $sampled(exp_grant & spoke_in_ready), $sampled(cand & spoke_in_ready));
            mismatch_cnt++;
        end

    for (genvar g = 0; g < `NUM_SPOKES; g++) begin : g_spoke_check
        a_spoke_extra: assert property (@(posedge clk) disable iff (!rst_n)
            spoke_out[g].valid && spoke_out_ready[g] |-> spoke_exp_ok[g])
            else begin
                $display("spoke_out[%0d] delivered a beat that the hub never sent", g);
                fault_cnt++;
            end

        a_spoke_value: assert property (@(posedge clk) disable iff (!rst_n)
            spoke_out[g].valid && spoke_out_ready[g] && spoke_exp_ok[g] |->
            spoke_out[g].beat == spoke_exp[g])
            else begin
                $display("MISMATCH spoke_out[%0d].beat expected %h actual %h",
                         g, spoke_exp[g], $sampled(spoke_out[g].beat));
                mismatch_cnt++;
            end

        a_spoke_stable: assert property (@(posedge clk) disable iff (!rst_n)
            spoke_out[g].valid && !spoke_out_ready[g] |=>
            spoke_out[g].valid && $stable(spoke_out[g].beat))
            else begin
                $display("spoke_out[%0d] changed while stalled", g);
                fault_cnt++;
            end

        // beats for anywhere but the hub are dropped at once
        a_spoke_discard: assert property (@(posedge clk) disable iff (!rst_n)
            spoke_in[g].valid && !cand[g] |-> spoke_in_ready[g])
            else begin
                $display("stray beat on spoke input %0d was not accepted", g);
                fault_cnt++;
            end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 50;   // 100 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release lands on a falling edge like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
axis_pkg.sv
switch_pkg.sv
axis_skid_slice.sv
hub_dest_demux.sv
spoke_priority_arbiter.sv
axis_hub_switch.sv
tb_clock_gen.sv
tb_axis_hub_switch.sv
